//--- design/dt_debug_pkg.sv
/*
 * Debug timing package for the analog spin array.
 * Sizes, vector types, register map and counter states.
 */
`default_nettype none

package dt_debug_pkg;

    // Array geometry
    localparam int NUM_SPIN         = 8;
    localparam int BITDATA          = 4;
    localparam int COUNTER_BITWIDTH = 16;

    // Wishbone sizes
    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 3;

    typedef logic [COUNTER_BITWIDTH-1:0]  cycle_cnt_t;
    typedef logic [NUM_SPIN-1:0]          row_sel_t;
    typedef logic [NUM_SPIN*BITDATA-1:0]  bitline_t;
    typedef logic [WB_DATA_W-1:0]         wb_data_t;
    typedef logic [WB_ADDR_W-1:0]         wb_addr_t;

    // Register word addresses
    localparam wb_addr_t ADDR_CTRL   = 3'd0;
    localparam wb_addr_t ADDR_CFG    = 3'd1;
    localparam wb_addr_t ADDR_SEL    = 3'd2;
    localparam wb_addr_t ADDR_WDATA  = 3'd3;
    localparam wb_addr_t ADDR_CMD    = 3'd4;
    localparam wb_addr_t ADDR_STATUS = 3'd5;
    localparam wb_addr_t ADDR_RDATA  = 3'd6;

    // Bit positions inside CMD
    localparam int CMD_WR_BIT = 0;
    localparam int CMD_RD_BIT = 1;

    // Phase counter states
    typedef enum logic {
        PH_IDLE,
        PH_COUNT
    } phase_state_t;

endpackage

`default_nettype wire

//--- design/step_counter.sv
/*
 * Phase length counter with a loadable limit.
 * Flags the step that reaches the limit, then clears itself.
 */
`default_nettype none

module step_counter import dt_debug_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       en_i,
    input  logic       load_i,
    input  cycle_cnt_t limit_i,
    input  logic       recount_i,
    input  logic       step_en_i,
    output logic       maxed_o
);

    phase_state_t state_q;
    cycle_cnt_t   limit_q;
    cycle_cnt_t   count_q;
    cycle_cnt_t   count_next;
    logic         step;

    assign step = en_i & step_en_i;

    // First step after idle counts as one
    assign count_next = (state_q == PH_COUNT) ? count_q + 1'b1 : cycle_cnt_t'(1);

    assign maxed_o = step & (count_next == limit_q);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            limit_q <= '0;
        end else if (load_i) begin
            limit_q <= limit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || !en_i || recount_i) begin
            state_q <= PH_IDLE;
            count_q <= '0;
        end else if (step) begin
            if (maxed_o) begin
                // Wrap back so the next phase starts fresh
                state_q <= PH_IDLE;
                count_q <= '0;
            end else begin
                state_q <= PH_COUNT;
                count_q <= count_next;
            end
        end
    end

    // A zero limit would never terminate the phase
    a_limit_nonzero: assert property (
        @(posedge clk_i) disable iff (reset_i)
        step_en_i |-> (limit_q != '0)
    ) else $error("step_counter stepping with a zero limit");

endmodule

`default_nettype wire

//--- design/analog_dt_debug.sv
/*
 * Write/read timing for the analog spin array debug port.
 * Drives one word line for the high phase, then waits out the low phase.
 */
`default_nettype none

module analog_dt_debug import dt_debug_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       en_i,
    // Phase configuration
    input  logic       configure_enable_i,
    input  cycle_cnt_t cycle_per_wwl_high_i,
    input  cycle_cnt_t cycle_per_wwl_low_i,
    // Commands and data from the register block
    input  logic       debug_wen_i,
    input  logic       debug_ren_i,
    input  row_sel_t   debug_j_one_hot_wwl_i,
    input  logic       debug_h_wwl_i,
    input  bitline_t   debug_wdata_i,
    output logic       wwl_high_counter_maxed_o,
    // Analog array side
    output row_sel_t   j_one_hot_wwl_o,
    output logic       h_wwl_o,
    output bitline_t   wbl_o,
    // Status
    output logic       debug_dt_idle_o,
    output logic       debug_dt_w_idle_o,
    output logic       debug_dt_r_idle_o
);

    logic     w_busy_q;
    logic     r_busy_q;
    logic     busy;
    logic     start_w;
    logic     start_r;
    logic     start;
    logic     high_active_q;
    logic     low_active_q;
    logic     high_maxed;
    logic     low_maxed;
    logic     high_end;
    logic     op_end;
    row_sel_t j_wwl_q;
    logic     h_wwl_q;
    bitline_t wbl_q;

    assign busy = w_busy_q | r_busy_q;

    // Write has priority and a command arriving while busy is dropped
    assign start_w = en_i & ~busy & debug_wen_i;
    assign start_r = en_i & ~busy & ~debug_wen_i & debug_ren_i;
    assign start   = start_w | start_r;

    // Dropping enable aborts either phase
    assign high_end = ~en_i | high_maxed;
    assign op_end   = ~en_i | low_maxed;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            w_busy_q      <= 1'b0;
            r_busy_q      <= 1'b0;
            high_active_q <= 1'b0;
            low_active_q  <= 1'b0;
        end else begin
            if (op_end) begin
                w_busy_q <= 1'b0;
                r_busy_q <= 1'b0;
            end else begin
                if (start_w) w_busy_q <= 1'b1;
                if (start_r) r_busy_q <= 1'b1;
            end

            if (high_end) begin
                high_active_q <= 1'b0;
            end else if (start) begin
                high_active_q <= 1'b1;
            end

            if (op_end) begin
                low_active_q <= 1'b0;
            end else if (high_maxed) begin
                low_active_q <= 1'b1;
            end
        end
    end

    // Word line held for the high phase only
    always_ff @(posedge clk_i) begin
        if (reset_i || high_end) begin
            j_wwl_q <= '0;
            h_wwl_q <= 1'b0;
        end else if (start) begin
            j_wwl_q <= debug_j_one_hot_wwl_i;
            h_wwl_q <= debug_h_wwl_i;
        end
    end

    // Bit lines carry write data through both phases
    always_ff @(posedge clk_i) begin
        if (reset_i || op_end) begin
            wbl_q <= '0;
        end else if (start_w) begin
            wbl_q <= debug_wdata_i;
        end
    end

    step_counter i_wwl_high_counter (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .en_i      (en_i),
        .load_i    (configure_enable_i),
        .limit_i   (cycle_per_wwl_high_i),
        .recount_i (start),
        .step_en_i (high_active_q),
        .maxed_o   (high_maxed)
    );

    step_counter i_wwl_low_counter (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .en_i      (en_i),
        .load_i    (configure_enable_i),
        .limit_i   (cycle_per_wwl_low_i),
        .recount_i (start),
        .step_en_i (low_active_q),
        .maxed_o   (low_maxed)
    );

    assign wwl_high_counter_maxed_o = high_maxed;
    assign j_one_hot_wwl_o          = j_wwl_q;
    assign h_wwl_o                  = h_wwl_q;
    assign wbl_o                    = wbl_q;
    assign debug_dt_idle_o          = ~busy;
    assign debug_dt_w_idle_o        = ~w_busy_q;
    assign debug_dt_r_idle_o        = ~r_busy_q;

    a_j_onehot: assert property (
        @(posedge clk_i) disable iff (reset_i)
        $onehot0(j_one_hot_wwl_o)
    ) else $error("more than one J word line driven");

    a_busy_exclusive: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(w_busy_q && r_busy_q)
    ) else $error("write and read busy at the same time");

endmodule

`default_nettype wire

//--- design/debug_wb_regs.sv
/*
 * Wishbone classic register block for the debug timing unit.
 * Holds configuration, issues command pulses, captures read data.
 */
`default_nettype none

module debug_wb_regs import dt_debug_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    // Wishbone classic slave
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  wb_addr_t   wb_adr_i,
    input  wb_data_t   wb_dat_i,
    output wb_data_t   wb_dat_o,
    output logic       wb_ack_o,
    // Read bit lines from the array
    input  bitline_t   analog_rbl_i,
    // Towards the timing block
    output logic       en_o,
    output logic       configure_enable_o,
    output cycle_cnt_t cycle_per_wwl_high_o,
    output cycle_cnt_t cycle_per_wwl_low_o,
    output logic       debug_wen_o,
    output logic       debug_ren_o,
    output row_sel_t   debug_j_one_hot_wwl_o,
    output logic       debug_h_wwl_o,
    output bitline_t   debug_wdata_o,
    // Back from the timing block
    input  logic       wwl_high_counter_maxed_i,
    input  logic       debug_dt_idle_i,
    input  logic       debug_dt_w_idle_i,
    input  logic       debug_dt_r_idle_i
);

    logic       ack_q;
    logic       wr_en;
    logic       cfg_wr;
    logic       cmd_wr;
    logic       ctrl_en_q;
    cycle_cnt_t cfg_high_q;
    cycle_cnt_t cfg_low_q;
    row_sel_t   sel_j_q;
    logic       sel_h_q;
    bitline_t   wdata_q;
    bitline_t   rdata_q;
    logic       read_cmd_q;

    // Ack one cycle after cyc and stb and never back to back
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc_i & wb_stb_i & ~ack_q;
        end
    end

    assign wb_ack_o = ack_q;
    assign wr_en    = ack_q & wb_we_i;
    assign cfg_wr   = wr_en & (wb_adr_i == ADDR_CFG);
    assign cmd_wr   = wr_en & (wb_adr_i == ADDR_CMD);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_en_q  <= 1'b0;
            cfg_high_q <= '0;
            cfg_low_q  <= '0;
            sel_j_q    <= '0;
            sel_h_q    <= 1'b0;
        end else if (wr_en) begin
            case (wb_adr_i)
                ADDR_CTRL: ctrl_en_q <= wb_dat_i[0];
                ADDR_CFG: begin
                    cfg_high_q <= wb_dat_i[COUNTER_BITWIDTH-1:0];
                    cfg_low_q  <= wb_dat_i[2*COUNTER_BITWIDTH-1:COUNTER_BITWIDTH];
                end
                ADDR_SEL: begin
                    sel_j_q <= wb_dat_i[NUM_SPIN-1:0];
                    sel_h_q <= wb_dat_i[NUM_SPIN];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en && (wb_adr_i == ADDR_WDATA)) begin
            wdata_q <= wb_dat_i;
        end
    end

    // Only a command seen while idle can start, so only then is it recorded
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            read_cmd_q <= 1'b0;
        end else if (cmd_wr && debug_dt_idle_i) begin
            read_cmd_q <= ~wb_dat_i[CMD_WR_BIT] & wb_dat_i[CMD_RD_BIT];
        end
    end

    // Sample the array at the last cycle of the word-line pulse
    always_ff @(posedge clk_i) begin
        if (wwl_high_counter_maxed_i && read_cmd_q) begin
            rdata_q <= analog_rbl_i;
        end
    end

    always_comb begin
        wb_dat_o = '0;
        case (wb_adr_i)
            ADDR_CTRL:   wb_dat_o[0] = ctrl_en_q;
            ADDR_CFG:    wb_dat_o = {cfg_low_q, cfg_high_q};
            ADDR_SEL:    wb_dat_o[NUM_SPIN:0] = {sel_h_q, sel_j_q};
            ADDR_WDATA:  wb_dat_o = wdata_q;
            ADDR_STATUS: wb_dat_o[2:0] = {debug_dt_r_idle_i, debug_dt_w_idle_i, debug_dt_idle_i};
            ADDR_RDATA:  wb_dat_o = rdata_q;
            default:     wb_dat_o = '0;
        endcase
    end

    assign en_o               = ctrl_en_q;
    assign configure_enable_o = cfg_wr;

    // Counters load during the ack cycle, so the new limits bypass the register
    assign cycle_per_wwl_high_o = cfg_wr ? wb_dat_i[COUNTER_BITWIDTH-1:0] : cfg_high_q;
    assign cycle_per_wwl_low_o  = cfg_wr ? wb_dat_i[2*COUNTER_BITWIDTH-1:COUNTER_BITWIDTH]
                                         : cfg_low_q;

    assign debug_wen_o           = cmd_wr & wb_dat_i[CMD_WR_BIT];
    assign debug_ren_o           = cmd_wr & wb_dat_i[CMD_RD_BIT];
    assign debug_j_one_hot_wwl_o = sel_j_q;
    assign debug_h_wwl_o         = sel_h_q;
    assign debug_wdata_o         = wdata_q;

    // Relies on the master holding the request until it is acknowledged
    a_ack_in_cycle: assert property (
        @(posedge clk_i) disable iff (reset_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i)
    ) else $error("Wishbone ack raised without an active cycle");

endmodule

`default_nettype wire

//--- design/dt_debug_top.sv
/*
 * Debug timing top level.
 * Joins the Wishbone register block to the analog timing block.
 */
`default_nettype none

module dt_debug_top import dt_debug_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    // Wishbone classic slave
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  wb_addr_t wb_adr_i,
    input  wb_data_t wb_dat_i,
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o,
    // Analog array pins
    input  bitline_t analog_rbl_i,
    output row_sel_t j_one_hot_wwl_o,
    output logic     h_wwl_o,
    output bitline_t wbl_o
);

    logic       en;
    logic       configure_enable;
    cycle_cnt_t cycle_per_wwl_high;
    cycle_cnt_t cycle_per_wwl_low;
    logic       debug_wen;
    logic       debug_ren;
    row_sel_t   debug_j_one_hot_wwl;
    logic       debug_h_wwl;
    bitline_t   debug_wdata;
    logic       wwl_high_counter_maxed;
    logic       debug_dt_idle;
    logic       debug_dt_w_idle;
    logic       debug_dt_r_idle;

    debug_wb_regs i_regs (
        .clk_i                    (clk_i),
        .reset_i                  (reset_i),
        .wb_cyc_i                 (wb_cyc_i),
        .wb_stb_i                 (wb_stb_i),
        .wb_we_i                  (wb_we_i),
        .wb_adr_i                 (wb_adr_i),
        .wb_dat_i                 (wb_dat_i),
        .wb_dat_o                 (wb_dat_o),
        .wb_ack_o                 (wb_ack_o),
        .analog_rbl_i             (analog_rbl_i),
        .en_o                     (en),
        .configure_enable_o       (configure_enable),
        .cycle_per_wwl_high_o     (cycle_per_wwl_high),
        .cycle_per_wwl_low_o      (cycle_per_wwl_low),
        .debug_wen_o              (debug_wen),
        .debug_ren_o              (debug_ren),
        .debug_j_one_hot_wwl_o    (debug_j_one_hot_wwl),
        .debug_h_wwl_o            (debug_h_wwl),
        .debug_wdata_o            (debug_wdata),
        .wwl_high_counter_maxed_i (wwl_high_counter_maxed),
        .debug_dt_idle_i          (debug_dt_idle),
        .debug_dt_w_idle_i        (debug_dt_w_idle),
        .debug_dt_r_idle_i        (debug_dt_r_idle)
    );

    analog_dt_debug i_dt (
        .clk_i                    (clk_i),
        .reset_i                  (reset_i),
        .en_i                     (en),
        .configure_enable_i       (configure_enable),
        .cycle_per_wwl_high_i     (cycle_per_wwl_high),
        .cycle_per_wwl_low_i      (cycle_per_wwl_low),
        .debug_wen_i              (debug_wen),
        .debug_ren_i              (debug_ren),
        .debug_j_one_hot_wwl_i    (debug_j_one_hot_wwl),
        .debug_h_wwl_i            (debug_h_wwl),
        .debug_wdata_i            (debug_wdata),
        .wwl_high_counter_maxed_o (wwl_high_counter_maxed),
        .j_one_hot_wwl_o          (j_one_hot_wwl_o),
        .h_wwl_o                  (h_wwl_o),
        .wbl_o                    (wbl_o),
        .debug_dt_idle_o          (debug_dt_idle),
        .debug_dt_w_idle_o        (debug_dt_w_idle),
        .debug_dt_r_idle_o        (debug_dt_r_idle)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
/*
 * Free running testbench clock, 20 time units per period.
 */
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    localparam int HALF_PERIOD = 10;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
/*
 * Testbench checker for the debug timing block.
 * Measures word-line and bit-line pulses, compares values, counts errors.
 */
`default_nettype none

module tb_checker import dt_debug_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_ack_i,
    input  row_sel_t j_one_hot_wwl_i,
    input  logic     h_wwl_i,
    input  bitline_t wbl_i,
    output int       mismatch_count_o,
    output int       failure_count_o
);

    int                mismatches = 0;
    int                failures   = 0;
    // Run length of the pulse in progress and the last finished one
    int                wl_run     = 0;
    int                wl_width   = 0;
    int                wl_pulses  = 0;
    logic [NUM_SPIN:0] wl_val     = '0;
    int                wbl_run    = 0;
    int                wbl_width  = 0;
    int                wbl_pulses = 0;
    bitline_t          wbl_val    = '0;
    logic [NUM_SPIN:0] wl_now;

    assign wl_now           = {h_wwl_i, j_one_hot_wwl_i};
    assign mismatch_count_o = mismatches;
    assign failure_count_o  = failures;

    task automatic report_failure(input string msg);
        failures++;
        $display("ERROR: %s", msg);
    endtask

    task automatic compare_value(input string test, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH test %s, %s: expected %h, actual %h", test, field, exp, act);
        end
    endtask

    task automatic verify_pulse_counts(input string test, input int exp_wl, input int exp_wbl);
        compare_value(test, "word-line pulse count", exp_wl, wl_pulses);
        compare_value(test, "bit-line pulse count", exp_wbl, wbl_pulses);
    endtask

    task automatic check_word_line(input string test, input logic [NUM_SPIN:0] val,
                                   input int width);
        compare_value(test, "word-line value", val, wl_val);
        compare_value(test, "word-line width", width, wl_width);
    endtask

    task automatic check_bit_lines(input string test, input bitline_t val, input int width);
        compare_value(test, "bit-line value", val, wbl_val);
        compare_value(test, "bit-line width", width, wbl_width);
    endtask

    task automatic expect_lines_zero(input string test);
        compare_value(test, "word lines", '0, wl_now);
        compare_value(test, "bit lines", '0, wbl_i);
    endtask

    // Outputs settle after the rising edge, so sample mid-cycle
    always @(negedge clk_i) begin
        if (!reset_i) begin
            if (wb_ack_i && !(wb_cyc_i && wb_stb_i)) begin
                report_failure("Wishbone ack seen without cyc and stb");
            end
            if (wl_now != '0) begin
                if (wl_run == 0) begin
                    wl_val = wl_now;
                end else if (wl_now != wl_val) begin
                    report_failure("word line changed in the middle of a pulse");
                end
                wl_run++;
            end else if (wl_run != 0) begin
                wl_width = wl_run;
                wl_pulses++;
                wl_run = 0;
            end
            if (wbl_i != '0) begin
                if (wbl_run == 0) begin
                    wbl_val = wbl_i;
                end else if (wbl_i != wbl_val) begin
                    report_failure("bit lines changed in the middle of a write");
                end
                wbl_run++;
            end else if (wbl_run != 0) begin
                wbl_width = wbl_run;
                wbl_pulses++;
                wbl_run = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_dt_debug.sv
/*
 * Testbench for the debug timing top level.
 * Runs the tests of the input file over Wishbone and models the read bit lines.
 */
`default_nettype none

module tb_dt_debug import dt_debug_pkg::*; ();

    localparam int MAX_TESTS = 64;
    localparam int ACK_LIMIT = 16;

    logic     clk;
    logic     reset;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    bitline_t analog_rbl;
    row_sel_t j_wwl;
    logic     h_wwl;
    bitline_t wbl;
    int       mismatch_count;
    int       failure_count;

    string    t_name [MAX_TESTS];
    string    t_op   [MAX_TESTS];
    wb_data_t t_a    [MAX_TESTS];
    wb_data_t t_b    [MAX_TESTS];
    wb_data_t t_exp  [MAX_TESTS];
    int       num_tests     = 0;
    int       timeout_limit = 100;
    int       cycle_count   = 0;
    string    cur_test      = "reset";

    // Reference model of the register contents
    cycle_cnt_t        cur_h          = '0;
    cycle_cnt_t        cur_l          = '0;
    logic [NUM_SPIN:0] cur_sel        = '0;
    bitline_t          cur_wdata      = '0;
    bitline_t          rbl_val        = '0;
    int                wl_high_cycles = 0;
    int                exp_wl_pulses  = 0;
    int                exp_wbl_pulses = 0;

    tb_clock_gen i_clk_gen (.clk_o(clk));

    dt_debug_top dut (
        .clk_i           (clk),
        .reset_i         (reset),
        .wb_cyc_i        (wb_cyc),
        .wb_stb_i        (wb_stb),
        .wb_we_i         (wb_we),
        .wb_adr_i        (wb_adr),
        .wb_dat_i        (wb_dat_w),
        .wb_dat_o        (wb_dat_r),
        .wb_ack_o        (wb_ack),
        .analog_rbl_i    (analog_rbl),
        .j_one_hot_wwl_o (j_wwl),
        .h_wwl_o         (h_wwl),
        .wbl_o           (wbl)
    );

    tb_checker i_checker (
        .clk_i            (clk),
        .reset_i          (reset),
        .wb_cyc_i         (wb_cyc),
        .wb_stb_i         (wb_stb),
        .wb_ack_i         (wb_ack),
        .j_one_hot_wwl_i  (j_wwl),
        .h_wwl_i          (h_wwl),
        .wbl_i            (wbl),
        .mismatch_count_o (mismatch_count),
        .failure_count_o  (failure_count)
    );

    // Array model presents the read value only in the last cycle of the word-line pulse
    always @(posedge clk) begin
        #2;
        if ({h_wwl, j_wwl} != '0) begin
            wl_high_cycles++;
        end else begin
            wl_high_cycles = 0;
        end
        analog_rbl = (wl_high_cycles == int'(cur_h)) ? rbl_val : ~rbl_val;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: test %s still running after %0d cycles", cur_test, cycle_count);
            $display("Error count: %0d mismatches, %0d other failures",
                     mismatch_count, failure_count + 1);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic load_tests();
        int         fd;
        int         n;
        string      line;
        string      name;
        string      op;
        wb_data_t   a;
        wb_data_t   b;
        wb_data_t   e;
        cycle_cnt_t lim_h;
        cycle_cnt_t lim_l;
        lim_h = '0;
        lim_l = '0;
        fd = $fopen("sim/dt_debug_input.txt", "r");
        if (fd == 0) begin
            i_checker.report_failure("could not open the test file sim/dt_debug_input.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s %h %h %h", name, op, a, b, e);
                if (n == 5 && name.getc(0) != "#" && num_tests < MAX_TESTS) begin
                    t_name[num_tests] = name;
                    t_op[num_tests]   = op;
                    t_a[num_tests]    = a;
                    t_b[num_tests]    = b;
                    t_exp[num_tests]  = e;
                    if (op == "cfg") begin
                        lim_h = a[COUNTER_BITWIDTH-1:0];
                        lim_l = b[COUNTER_BITWIDTH-1:0];
                    end
                    timeout_limit += int'(lim_h) + int'(lim_l) + 20;
                    num_tests++;
                end
            end
            $fclose(fd);
        end
        if (num_tests == 0) begin
            i_checker.report_failure("no tests were read from the test file");
        end
    endtask

    // Classic cycle held until ack with inputs changing 2 units after the edge
    task automatic wb_xfer(input logic we, input wb_addr_t adr, input wb_data_t dat,
                           output wb_data_t rdat);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(posedge clk);
        #2;
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!wb_ack) begin
            i_checker.report_failure($sformatf("no Wishbone ack for address %0d in test %s",
                                               adr, cur_test));
        end
        rdat = wb_dat_r;
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic reg_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        wb_xfer(1'b1, adr, dat, unused);
    endtask

    task automatic reg_check(input string field, input wb_addr_t adr, input wb_data_t exp);
        wb_data_t rdat;
        wb_xfer(1'b0, adr, '0, rdat);
        i_checker.compare_value(cur_test, field, exp, rdat);
    endtask

    task automatic wait_idle();
        wb_data_t st;
        st = '0;
        while (!st[0]) begin
            wb_xfer(1'b0, ADDR_STATUS, '0, st);
        end
    endtask

    task automatic run_operation(input int i);
        logic     is_read;
        wb_data_t cmd;
        is_read = (t_op[i] == "read");
        cmd     = is_read ? 32'd2 : t_a[i];
        if (is_read) begin
            rbl_val = t_a[i];
        end
        reg_write(ADDR_CMD, cmd);
        // Optional second command issued while busy and expected to be dropped
        if (t_b[i] != '0) begin
            reg_write(ADDR_CMD, t_b[i]);
        end
        reg_check("busy STATUS", ADDR_STATUS, t_exp[i]);
        wait_idle();
        reg_check("idle STATUS", ADDR_STATUS, 32'd7);
        exp_wl_pulses++;
        if (!is_read) begin
            exp_wbl_pulses++;
        end
        i_checker.verify_pulse_counts(cur_test, exp_wl_pulses, exp_wbl_pulses);
        i_checker.check_word_line(cur_test, cur_sel, cur_h);
        if (is_read) begin
            reg_check("RDATA", ADDR_RDATA, t_a[i]);
        end else begin
            i_checker.check_bit_lines(cur_test, cur_wdata, int'(cur_h) + int'(cur_l));
        end
    endtask

    task automatic run_abort(input int i);
        reg_write(ADDR_CMD, t_a[i]);
        reg_write(ADDR_CTRL, 32'd0);
        // Lines drop one cycle after enable clears
        @(posedge clk);
        #2;
        i_checker.expect_lines_zero(cur_test);
        reg_check("abort STATUS", ADDR_STATUS, t_exp[i]);
        exp_wl_pulses++;
        if (t_a[i][0]) begin
            exp_wbl_pulses++;
        end
        i_checker.verify_pulse_counts(cur_test, exp_wl_pulses, exp_wbl_pulses);
        reg_write(ADDR_CTRL, 32'd1);
    endtask

    task automatic run_test(input int i);
        cur_test = t_name[i];
        case (t_op[i])
            "cfg": begin
                cur_h = t_a[i][COUNTER_BITWIDTH-1:0];
                cur_l = t_b[i][COUNTER_BITWIDTH-1:0];
                reg_write(ADDR_CTRL, 32'd1);
                reg_write(ADDR_CFG, {cur_l, cur_h});
                reg_check("CTRL", ADDR_CTRL, 32'd1);
                reg_check("CFG", ADDR_CFG, t_exp[i]);
            end
            "sel": begin
                // J row byte plus the H bit
                cur_sel = t_a[i][NUM_SPIN:0];
                reg_write(ADDR_SEL, t_a[i]);
                reg_check("SEL", ADDR_SEL, t_exp[i]);
            end
            "wdata": begin
                cur_wdata = t_a[i];
                reg_write(ADDR_WDATA, t_a[i]);
                reg_check("WDATA", ADDR_WDATA, t_exp[i]);
            end
            "write", "read": run_operation(i);
            "abort": run_abort(i);
            "status": begin
                if (t_b[i] != '0) begin
                    reg_write(t_a[i][WB_ADDR_W-1:0], t_b[i]);
                end
                reg_check("register read", t_a[i][WB_ADDR_W-1:0], t_exp[i]);
            end
            default: begin
                i_checker.report_failure($sformatf("unknown operation %s in test %s",
                                                   t_op[i], t_name[i]));
            end
        endcase
    endtask

    initial begin
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        analog_rbl = '0;
        load_tests();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        i_checker.expect_lines_zero(cur_test);
        i_checker.compare_value(cur_test, "ack", 32'd0, wb_ack);
        reg_check("reset STATUS", ADDR_STATUS, 32'd7);
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        cur_test = "end";
        @(posedge clk);
        #2;
        $display("Error count: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/dt_debug_input.txt
# name op a b exp, values in hex
# cfg a=high b=low; sel/wdata a=value; write a=cmd b=cmd while busy; read a=rbl; status a=addr b=wdata
reg_cfg        cfg     3         4         00040003
reg_sel_j2     sel     4         0         00000004
reg_wdata      wdata   a5c31e7f  0         a5c31e7f
wr_j2          write   1         0         4
rd_j2          read    3c96f00d  0         2
reg_sel_h      sel     100       0         00000100
wr_h           write   1         0         4
reg_cfg_long   cfg     5         3         00030005
reg_sel_j7     sel     80        0         00000080
reg_wdata2     wdata   12345678  0         12345678
wr_busy_drop   write   1         2         4
rd_busy_drop   read    0badcafe  1         2
wr_priority    write   3         0         4
reg_sel_mask   sel     fffffe01  0         00000001
reg_cfg_abort  cfg     c         2         0002000c
abort_wr       abort   1         0         7
rd_after_abort read    5a5aa5a5  0         2
unmapped       status  7         deadbeef  0
status_idle    status  5         0         7
rdata_back     status  6         0         5a5aa5a5

//--- tb.f
design/dt_debug_pkg.sv
design/step_counter.sv
design/analog_dt_debug.sv
design/debug_wb_regs.sv
design/dt_debug_top.sv
sim/tb_clock_gen.sv
sim/tb_checker.sv
sim/tb_dt_debug.sv

//--- Bender.yml
package:
  name: dt_debug

sources:
  - files:
      - design/dt_debug_pkg.sv
      - design/step_counter.sv
      - design/analog_dt_debug.sv
      - design/debug_wb_regs.sv
      - design/dt_debug_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_checker.sv
      - sim/tb_dt_debug.sv
